//--- exec_pkg.sv
/* shared widths, opcode codes and control bit positions for the execute cluster
   every module and interface imports this by wildcard in its header */
`default_nettype none

package exec_pkg;

	localparam int xlen = 32;  // operand and result width
	localparam int rob_w = 3;  // reorder-buffer tag
	localparam int op_w = 3;

	// codes 0 to 4 go to the add unit and 5 to 7 to the logic unit
	localparam logic [op_w-1:0] op_add = 3'd0;
	localparam logic [op_w-1:0] op_sub = 3'd1;
	localparam logic [op_w-1:0] op_beq = 3'd2;
	localparam logic [op_w-1:0] op_bne = 3'd3;
	localparam logic [op_w-1:0] op_blt = 3'd4;  // signed compare
	localparam logic [op_w-1:0] op_and = 3'd5;
	localparam logic [op_w-1:0] op_or = 3'd6;
	localparam logic [op_w-1:0] op_xor = 3'd7;

	// unit-local control widths
	localparam int add_ctl_w = 4;
	localparam int logic_ctl_w = 2;  // low opcode bits pass through unchanged

	// bit positions inside the add unit ctl
	localparam int ctl_sub = 0;  // also set for every branch
	localparam int ctl_beq = 1;
	localparam int ctl_bne = 2;
	localparam int ctl_blt = 3;

	// last opcode that still belongs to the add unit
	localparam logic [op_w-1:0] op_last_add = op_blt;

endpackage

`default_nettype wire

//--- issue_if.sv
/* one decoded operation from the issue router to a functional unit
   ctl_w is set per instance, add_ctl_w for the add unit and logic_ctl_w otherwise */
`timescale 1ns/100ps
`default_nettype none

interface issue_if
	import exec_pkg::*;
#(
	parameter int ctl_w = add_ctl_w
);
	logic valid;  // one cycle strobe
	logic [xlen-1:0] rs1;
	logic [xlen-1:0] rs2;
	logic [rob_w-1:0] tag;
	logic [ctl_w-1:0] ctl;
	logic full;  // unit holds an unconsumed result

	// router never strobes valid while full is high
	modport router (output valid, rs1, rs2, tag, ctl, input full);
	modport unit (input valid, rs1, rs2, tag, ctl, output full);

endinterface

`default_nettype wire

//--- result_if.sv
/* held result from a functional unit to the bus arbiter
   valid stays up until the clock after yumi */
`timescale 1ns/100ps
`default_nettype none

interface result_if
	import exec_pkg::*;
;
	logic valid;  // level
	logic [xlen-1:0] result;
	logic taken;  // branch outcome, low for plain ops
	logic [rob_w-1:0] tag;
	logic yumi;  // consume pulse from the arbiter

	// yumi is only raised while valid is high
	modport unit (output valid, result, taken, tag, input yumi);
	modport arb (input valid, result, taken, tag, output yumi);

endinterface

`default_nettype wire

//--- add_unit.sv
/* add/sub functional unit with a ripple-carry adder and branch evaluation
   registers one tagged result on issue and holds it until the arbiter takes it
   branches issue with sub set so the flags come from rs1 - rs2 */
`timescale 1ns/100ps
`default_nettype none

module add_unit
	import exec_pkg::*;
(
	input logic clk,
	input logic reset,
	issue_if.unit iss,
	result_if.unit res
);

	logic sub;
	logic [xlen-1:0] b_op;
	logic [xlen-1:0] sum;
	logic [xlen:0] carry;
	logic zero;
	logic negative;
	logic overflow;
	logic taken_next;
	logic valid_q;

	assign sub = iss.ctl[ctl_sub];
	assign b_op = sub ? ~iss.rs2 : iss.rs2;  // two's complement with carry-in
	assign carry[0] = sub;

	// one full-adder cell per bit
	genvar i;
	generate
		for (i = 0; i < xlen; i++) begin : g_fa
			assign sum[i] = iss.rs1[i] ^ b_op[i] ^ carry[i];
			assign carry[i+1] = (iss.rs1[i] & b_op[i]) |
				(carry[i] & (iss.rs1[i] ^ b_op[i]));
		end
	endgenerate

	assign zero = ~|sum;
	assign negative = sum[xlen-1];
	assign overflow = carry[xlen] ^ carry[xlen-1];  // carry into and out of the sign bit

	// signed less-than is negative xor overflow of the difference
	assign taken_next = (iss.ctl[ctl_bne] & ~zero) |
		(iss.ctl[ctl_beq] & zero) |
		(iss.ctl[ctl_blt] & (negative ^ overflow));

	always_ff @(posedge clk) begin
		if (reset) begin
			valid_q <= 1'b0;
		end else if (iss.valid) begin
			valid_q <= 1'b1;
		end else if (res.yumi) begin
			valid_q <= 1'b0;  // consumed on the bus
		end
	end

	always_ff @(posedge clk) begin
		if (iss.valid) begin
			res.result <= sum;
			res.tag <= iss.tag;
			res.taken <= taken_next;
		end
	end

	assign res.valid = valid_q;
	assign iss.full = valid_q;

	// the router must hold back issue while a result waits here
	a_no_issue_full: assert property (@(posedge clk) disable iff (reset)
		iss.valid |-> !valid_q)
		else $error("add_unit issued while full");

	// arbiter may only consume a result that is actually held
	a_yumi_valid: assert property (@(posedge clk) disable iff (reset)
		res.yumi |-> valid_q)
		else $error("add_unit yumi without valid");

endmodule

`default_nettype wire

//--- logic_unit.sv
/* bitwise functional unit for and, or and xor
   holds one tagged result until yumi, full mirrors the held valid */
`timescale 1ns/100ps
`default_nettype none

module logic_unit
	import exec_pkg::*;
(
	input logic clk,
	input logic reset,
	issue_if.unit iss,
	result_if.unit res
);

	logic [xlen-1:0] value;
	logic valid_q;

	// ctl carries the low opcode bits
	always_comb begin
		case (iss.ctl)
			op_and[logic_ctl_w-1:0]: value = iss.rs1 & iss.rs2;
			op_or[logic_ctl_w-1:0]: value = iss.rs1 | iss.rs2;
			default: value = iss.rs1 ^ iss.rs2;  // op_xor
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			valid_q <= 1'b0;
		end else if (iss.valid) begin
			valid_q <= 1'b1;
		end else if (res.yumi) begin
			valid_q <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (iss.valid) begin
			res.result <= value;
			res.tag <= iss.tag;
		end
	end

	assign res.taken = 1'b0;  // never a branch
	assign res.valid = valid_q;
	assign iss.full = valid_q;

	// router gating must keep a second op out until the first is taken
	a_no_issue_full: assert property (@(posedge clk) disable iff (reset)
		iss.valid |-> !valid_q)
		else $error("logic_unit issued while full");

endmodule

`default_nettype wire

//--- issue_router.sv
/* decodes the issued opcode and steers it to the add or logic unit
   purely combinational, issue_ready drops while the target unit is full */
`timescale 1ns/100ps
`default_nettype none

module issue_router
	import exec_pkg::*;
(
	input logic issue_valid,
	input logic [op_w-1:0] issue_op,
	input logic [xlen-1:0] issue_rs1,
	input logic [xlen-1:0] issue_rs2,
	input logic [rob_w-1:0] issue_tag,
	output logic issue_ready,
	issue_if.router add_iss,
	issue_if.router log_iss
);

	logic to_add;
	logic is_branch;

	assign to_add = (issue_op <= op_last_add);
	assign is_branch = (issue_op == op_beq) | (issue_op == op_bne) | (issue_op == op_blt);

	// add unit control in decoded form
	always_comb begin
		add_iss.ctl = '0;
		add_iss.ctl[ctl_sub] = (issue_op == op_sub) | is_branch;
		add_iss.ctl[ctl_beq] = (issue_op == op_beq);
		add_iss.ctl[ctl_bne] = (issue_op == op_bne);
		add_iss.ctl[ctl_blt] = (issue_op == op_blt);
	end

	assign log_iss.ctl = issue_op[logic_ctl_w-1:0];

	// operands and tag fan out to both units
	assign add_iss.rs1 = issue_rs1;
	assign add_iss.rs2 = issue_rs2;
	assign add_iss.tag = issue_tag;
	assign log_iss.rs1 = issue_rs1;
	assign log_iss.rs2 = issue_rs2;
	assign log_iss.tag = issue_tag;

	assign issue_ready = to_add ? ~add_iss.full : ~log_iss.full;

	// strobe only the target and only when it has room
	assign add_iss.valid = issue_valid & to_add & ~add_iss.full;
	assign log_iss.valid = issue_valid & ~to_add & ~log_iss.full;

endmodule

`default_nettype wire

//--- cdb_arbiter.sv
/* picks one held unit result per cycle for the common data bus
   round-robin when both wait, grant sticks while cdb_ready is low
   yumi goes to the granted unit in the cycle the bus takes it */
`timescale 1ns/100ps
`default_nettype none

module cdb_arbiter
	import exec_pkg::*;
(
	input logic clk,
	input logic reset,
	result_if.arb add_res,
	result_if.arb log_res,
	input logic cdb_ready,
	output logic cdb_valid,
	output logic [rob_w-1:0] cdb_tag,
	output logic [xlen-1:0] cdb_value,
	output logic cdb_taken
);

	logic prio_log;  // preferred unit when both are valid, 0 is add
	logic grant_add;
	logic grant_log;
	logic consume;

	assign grant_add = add_res.valid & (~log_res.valid | ~prio_log);
	assign grant_log = log_res.valid & (~add_res.valid | prio_log);

	assign cdb_valid = grant_add | grant_log;
	assign consume = cdb_valid & cdb_ready;

	// bus mux
	assign cdb_tag = grant_log ? log_res.tag : add_res.tag;
	assign cdb_value = grant_log ? log_res.result : add_res.result;
	assign cdb_taken = grant_log ? log_res.taken : add_res.taken;

	assign add_res.yumi = grant_add & cdb_ready;
	assign log_res.yumi = grant_log & cdb_ready;

	always_ff @(posedge clk) begin
		if (reset) begin
			prio_log <= 1'b0;  // add unit first
		end else if (consume) begin
			prio_log <= grant_add;  // other unit next time
		end else if (cdb_valid) begin
			prio_log <= grant_log;  // stalled, keep the current winner
		end
	end

	// a consumed result has to leave, or the bus would carry it twice
	a_add_clears: assert property (@(posedge clk) disable iff (reset)
		add_res.yumi |=> !add_res.valid)
		else $error("add result still valid after yumi");

	a_log_clears: assert property (@(posedge clk) disable iff (reset)
		log_res.yumi |=> !log_res.valid)
		else $error("logic result still valid after yumi");

	// a stalled bus must not change under the consumer
	a_bus_stable: assert property (@(posedge clk) disable iff (reset)
		cdb_valid && !cdb_ready |=> cdb_valid && $stable(cdb_tag) &&
			$stable(cdb_value) && $stable(cdb_taken))
		else $error("cdb changed while stalled");

endmodule

`default_nettype wire

//--- exec_cluster.sv
/* integer execute cluster top level with plain issue and bus ports
   wires the router to the add and logic units and both to the bus arbiter */
`timescale 1ns/100ps
`default_nettype none

module exec_cluster
	import exec_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic issue_valid,
	input logic [op_w-1:0] issue_op,
	input logic [xlen-1:0] issue_rs1,
	input logic [xlen-1:0] issue_rs2,
	input logic [rob_w-1:0] issue_tag,
	output logic issue_ready,
	input logic cdb_ready,
	output logic cdb_valid,
	output logic [rob_w-1:0] cdb_tag,
	output logic [xlen-1:0] cdb_value,
	output logic cdb_taken
);

	issue_if #(.ctl_w(add_ctl_w)) add_iss ();
	issue_if #(.ctl_w(logic_ctl_w)) log_iss ();
	result_if add_res ();
	result_if log_res ();

	issue_router u_router (
		.issue_valid (issue_valid),
		.issue_op (issue_op),
		.issue_rs1 (issue_rs1),
		.issue_rs2 (issue_rs2),
		.issue_tag (issue_tag),
		.issue_ready (issue_ready),
		.add_iss (add_iss.router),
		.log_iss (log_iss.router)
	);

	add_unit u_add (.clk(clk), .reset(reset), .iss(add_iss.unit), .res(add_res.unit));

	logic_unit u_logic (.clk(clk), .reset(reset), .iss(log_iss.unit), .res(log_res.unit));

	cdb_arbiter u_arb (
		.clk (clk),
		.reset (reset),
		.add_res (add_res.arb),
		.log_res (log_res.arb),
		.cdb_ready (cdb_ready),
		.cdb_valid (cdb_valid),
		.cdb_tag (cdb_tag),
		.cdb_value (cdb_value),
		.cdb_taken (cdb_taken)
	);

	// such an op is dropped by the router
	a_issue_dropped: assert property (@(posedge clk) disable iff (reset)
		issue_valid |-> issue_ready)
		else $error("issue while not ready, op dropped");

endmodule

`default_nettype wire

//--- tb_exec_cluster.sv
/* directed testbench for the execute cluster
   checks bus results against a local model of the opcode rules,
   then back-pressure and a mixed stream with a random cdb_ready */
`timescale 1ns/100ps
`default_nettype none

module tb_exec_cluster
	import exec_pkg::*;
;
	localparam int max_cycles = 2000;  // six tests of ~40 ops, a few cycles each

	logic clk;
	logic reset;
	logic issue_valid;
	logic [op_w-1:0] issue_op;
	logic [xlen-1:0] issue_rs1;
	logic [xlen-1:0] issue_rs2;
	logic [rob_w-1:0] issue_tag;
	logic issue_ready;
	logic cdb_ready;
	logic cdb_valid;
	logic [rob_w-1:0] cdb_tag;
	logic [xlen-1:0] cdb_value;
	logic cdb_taken;

	int errors;
	int results;
	int cycles;
	string cur_test;
	logic [31:0] lfsr;
	logic [rob_w-1:0] next_tag;

	// stream scoreboard, indexed by tag
	logic pend_valid [2**rob_w];
	logic [xlen-1:0] pend_val [2**rob_w];
	logic pend_taken [2**rob_w];
	logic pend_add [2**rob_w];
	logic add_busy;
	logic log_busy;
	int issued;
	int received;

	exec_cluster dut (.*);

	always #50 clk = ~clk;

	always @(posedge clk) begin
		cycles++;
		if (cycles >= max_cycles) begin
			$display("timeout after %0d cycles, a result never reached the bus", cycles);
			$display("TB FAILED");
			$finish;
		end
	end

	// taps 32, 22, 2, 1
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		logic fb;
		int i;
		r = '0;
		for (i = 0; i < n; i++) begin
			fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			r = {r[30:0], fb};
		end
		return r;
	endfunction

	function automatic logic [xlen-1:0] ref_value(input logic [op_w-1:0] op,
		input logic [xlen-1:0] a, input logic [xlen-1:0] b);
		case (op)
			op_add: return a + b;
			op_and: return a & b;
			op_or: return a | b;
			op_xor: return a ^ b;
			default: return a - b;  // sub and all branches
		endcase
	endfunction

	function automatic logic ref_taken(input logic [op_w-1:0] op,
		input logic [xlen-1:0] a, input logic [xlen-1:0] b);
		case (op)
			op_beq: return a == b;
			op_bne: return a != b;
			op_blt: return $signed(a) < $signed(b);
			default: return 1'b0;
		endcase
	endfunction

	task automatic show_mismatch(input string what, input logic [xlen-1:0] exp,
		input logic [xlen-1:0] act);
		errors++;
		$display("Fail %s %s: expected %h, actual %h", cur_test, what, exp, act);
	endtask

	task automatic flag_error(input string msg);
		errors++;
		$display("Error in %s: %s", cur_test, msg);
	endtask

	// one cycle of issue_valid, ready checked mid-cycle
	task automatic issue_one(input logic [op_w-1:0] op, input logic [xlen-1:0] a,
		input logic [xlen-1:0] b, input logic [rob_w-1:0] tag);
		@(posedge clk);
		issue_valid <= 1'b1;
		issue_op <= op;
		issue_rs1 <= a;
		issue_rs2 <= b;
		issue_tag <= tag;
		@(negedge clk);
		if (!issue_ready) flag_error("issue_ready low on an issue to a free unit");
		@(posedge clk);
		issue_valid <= 1'b0;
	endtask

	task automatic wait_result(input logic [rob_w-1:0] tag, input logic [xlen-1:0] value,
		input logic taken);
		do @(negedge clk); while (!cdb_valid);
		results++;
		if (cdb_tag !== tag) show_mismatch("tag", tag, cdb_tag);
		if (cdb_value !== value) show_mismatch("value", value, cdb_value);
		if (cdb_taken !== taken) show_mismatch("taken", taken, cdb_taken);
	endtask

	task automatic run_op(input logic [op_w-1:0] op, input logic [xlen-1:0] a,
		input logic [xlen-1:0] b);
		logic [rob_w-1:0] tag;
		tag = next_tag;
		next_tag = next_tag + 1'b1;
		issue_one(op, a, b, tag);
		wait_result(tag, ref_value(op, a, b), ref_taken(op, a, b));
	endtask

	task automatic test_reset_latency();
		int op;
		cur_test = "reset_latency";
		for (op = 0; op < 8; op++) begin
			@(posedge clk);
			issue_op <= op_w'(op);
			@(negedge clk);
			if (cdb_valid) flag_error("cdb_valid high after reset");
			if (!issue_ready) flag_error("issue_ready low after reset");
		end
		@(posedge clk);
		issue_valid <= 1'b1;
		issue_op <= op_add;
		issue_rs1 <= 32'd5;
		issue_rs2 <= 32'd7;
		issue_tag <= 3'd3;
		@(negedge clk);
		if (cdb_valid) flag_error("cdb_valid in the issue cycle");
		@(posedge clk);
		issue_valid <= 1'b0;
		@(negedge clk);
		if (!cdb_valid) begin
			flag_error("no result one cycle after issue");
		end else begin
			results++;
			if (cdb_tag !== 3'd3) show_mismatch("tag", 3'd3, cdb_tag);
			if (cdb_value !== 32'd12) show_mismatch("value", 32'd12, cdb_value);
		end
	endtask

	task automatic test_add_sub();
		logic [xlen-1:0] ea [5];
		logic [xlen-1:0] eb [5];
		logic [xlen-1:0] a, b;
		int i;
		cur_test = "add_sub";
		// max pos minus -1, 0 minus 1, max pos plus 1, min minus 1, -1 plus 1
		ea = '{32'h7fff_ffff, 32'h0, 32'h7fff_ffff, 32'h8000_0000, 32'hffff_ffff};
		eb = '{32'hffff_ffff, 32'h1, 32'h1, 32'h1, 32'h1};
		for (i = 0; i < 32; i++) begin
			a = rand_bits(32);
			b = rand_bits(32);
			run_op(op_add, a, b);
			run_op(op_sub, a, b);
		end
		for (i = 0; i < 5; i++) begin
			run_op(op_add, ea[i], eb[i]);
			run_op(op_sub, ea[i], eb[i]);
		end
	endtask

	task automatic test_branch();
		logic [xlen-1:0] ea [4];
		logic [xlen-1:0] eb [4];
		logic [xlen-1:0] a, b;
		logic [op_w-1:0] op;
		int i;
		cur_test = "branch";
		// difference overflows in the first three pairs
		ea = '{32'h8000_0000, 32'h7fff_ffff, 32'h1, 32'hffff_ffff};
		eb = '{32'h1, 32'hffff_ffff, 32'h8000_0000, 32'h0};
		for (op = op_beq; op <= op_blt; op++) begin
			for (i = 0; i < 8; i++) begin
				a = rand_bits(32);
				b = rand_bits(32);
				run_op(op, a, b);
				run_op(op, a, a);
			end
			for (i = 0; i < 4; i++) begin
				run_op(op, ea[i], eb[i]);
			end
		end
	endtask

	task automatic test_logic();
		logic [xlen-1:0] a, b;
		logic [op_w-1:0] op;
		int i;
		cur_test = "logic";
		for (i = 0; i < 36; i++) begin
			op = (i % 3 == 0) ? op_and : (i % 3 == 1) ? op_or : op_xor;
			a = rand_bits(32);
			b = rand_bits(32);
			run_op(op, a, b);
		end
	endtask

	task automatic test_backpressure();
		logic [xlen-1:0] a0, b0, a1, b1;
		logic [rob_w-1:0] t0, t1;
		logic [rob_w-1:0] seen_tag [$];
		logic [xlen-1:0] seen_val [$];
		int i;
		cur_test = "backpressure";
		a0 = rand_bits(32);
		b0 = rand_bits(32);
		a1 = rand_bits(32);
		b1 = rand_bits(32);
		t0 = next_tag;
		t1 = next_tag + 1'b1;
		next_tag = next_tag + 2'd2;
		@(posedge clk);
		cdb_ready <= 1'b0;
		issue_one(op_add, a0, b0, t0);
		issue_one(op_xor, a1, b1, t1);
		for (i = 0; i < 4; i++) begin
			@(negedge clk);
			if (!cdb_valid) flag_error("result not held under back-pressure");
			if (cdb_tag !== t0) show_mismatch("held tag", t0, cdb_tag);
			if (cdb_value !== ref_value(op_add, a0, b0))
				show_mismatch("held value", ref_value(op_add, a0, b0), cdb_value);
		end
		@(posedge clk);
		issue_op <= op_sub;
		@(negedge clk);
		if (issue_ready) flag_error("issue_ready high while the add unit is full");
		@(posedge clk);
		issue_op <= op_or;
		@(negedge clk);
		if (issue_ready) flag_error("issue_ready high while the logic unit is full");
		@(posedge clk);
		cdb_ready <= 1'b1;
		for (i = 0; i < 6; i++) begin
			@(negedge clk);
			if (cdb_valid) begin
				seen_tag.push_back(cdb_tag);
				seen_val.push_back(cdb_value);
			end
		end
		if (seen_tag.size() != 2) begin
			flag_error($sformatf("expected 2 results after release, saw %0d",
				seen_tag.size()));
		end else begin
			results += 2;
			if (seen_tag[0] !== t0) show_mismatch("first tag", t0, seen_tag[0]);
			if (seen_val[0] !== ref_value(op_add, a0, b0))
				show_mismatch("first value", ref_value(op_add, a0, b0), seen_val[0]);
			if (seen_tag[1] !== t1) show_mismatch("second tag", t1, seen_tag[1]);
			if (seen_val[1] !== ref_value(op_xor, a1, b1))
				show_mismatch("second value", ref_value(op_xor, a1, b1), seen_val[1]);
		end
	endtask

	// samples one cycle mid-way and retires a consumed bus result
	task automatic observe_bus();
		@(negedge clk);
		if (issue_valid && !issue_ready) flag_error("stream op dropped with issue_ready low");
		if (cdb_valid && cdb_ready) begin
			received++;
			results++;
			if (!pend_valid[cdb_tag]) begin
				flag_error($sformatf("tag %0d on the bus was not in flight", cdb_tag));
			end else begin
				if (cdb_value !== pend_val[cdb_tag])
					show_mismatch("value", pend_val[cdb_tag], cdb_value);
				if (cdb_taken !== pend_taken[cdb_tag])
					show_mismatch("taken", pend_taken[cdb_tag], cdb_taken);
				pend_valid[cdb_tag] = 1'b0;
				if (pend_add[cdb_tag]) add_busy = 1'b0;
				else log_busy = 1'b0;
			end
		end
	endtask

	task automatic test_stream();
		logic [xlen-1:0] a, b;
		logic [op_w-1:0] op;
		logic [31:0] r;
		logic to_add;
		logic turn_add;
		int k;
		cur_test = "stream";
		for (k = 0; k < 2**rob_w; k++) begin
			pend_valid[k] = 1'b0;
		end
		add_busy = 1'b0;
		log_busy = 1'b0;
		issued = 0;
		received = 0;
		turn_add = 1'b1;
		while (issued < 40) begin
			observe_bus();
			@(posedge clk);
			issue_valid <= 1'b0;
			r = rand_bits(1);
			cdb_ready <= r[0];
			to_add = turn_add ? !add_busy : log_busy;  // fall back to the other unit
			if (to_add ? !add_busy : !log_busy) begin
				k = rand_bits(3);
				op = to_add ? op_w'(k % 5) : op_and + op_w'(k % 3);
				a = rand_bits(32);
				b = rand_bits(32);
				issue_valid <= 1'b1;
				issue_op <= op;
				issue_rs1 <= a;
				issue_rs2 <= b;
				issue_tag <= next_tag;
				pend_valid[next_tag] = 1'b1;
				pend_val[next_tag] = ref_value(op, a, b);
				pend_taken[next_tag] = ref_taken(op, a, b);
				pend_add[next_tag] = to_add;
				if (to_add) add_busy = 1'b1;
				else log_busy = 1'b1;
				next_tag = next_tag + 1'b1;
				issued++;
				turn_add = !to_add;
			end
		end
		while (add_busy || log_busy) begin
			observe_bus();
			@(posedge clk);
			issue_valid <= 1'b0;
			cdb_ready <= 1'b1;
		end
		if (received != issued) show_mismatch("result count", issued, received);
	endtask

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		issue_valid = 1'b0;
		issue_op = '0;
		issue_rs1 = '0;
		issue_rs2 = '0;
		issue_tag = '0;
		cdb_ready = 1'b1;
		errors = 0;
		results = 0;
		cycles = 0;
		lfsr = 32'd4;
		next_tag = '0;
		repeat (16) @(posedge clk);
		reset <= 1'b0;
		test_reset_latency();
		test_add_sub();
		test_branch();
		test_logic();
		test_backpressure();
		test_stream();
		$display("results checked %0d, errors %0d", results, errors);
		if (errors == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- exec_cluster.f
exec_pkg.sv
issue_if.sv
result_if.sv
add_unit.sv
logic_unit.sv
issue_router.sv
cdb_arbiter.sv
exec_cluster.sv
tb_exec_cluster.sv
